/* design/sort_cfg_pkg.sv */
package sort_cfg_pkg;

    // --------------------
    // Sorter datapath sizes
    // --------------------

    // Width of one data word
    localparam int DEF_IW = 16;

    // Words in one frame with one comparator per word
    localparam int DEF_COL = 8;

    // Smallest entries sent out per frame (1 to DEF_COL)
    localparam int DEF_BEAM = 4;

endpackage

/* design/sort_ctrl_pkg.sv */
package sort_ctrl_pkg;

    // --------------------
    // Sequencer control types
    // --------------------

    // Sequencer states, in the order one frame walks through them
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_RANK    = 2'd1,
        ST_SCATTER = 2'd2,
        ST_EMIT    = 2'd3
    } sort_state_t;

endpackage

/* design/rank_compare.sv */
module rank_compare
    import sort_cfg_pkg::*;
#(
    parameter int IW      = DEF_IW,
    parameter int COL     = DEF_COL,
    parameter int INDEX   = 0,
    localparam int IXW    = (COL > 1) ? $clog2(COL) : 1
) (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_rank,
    input  logic [COL-1:0][IW-1:0] i_frame,
    output logic [IXW-1:0]         o_rank
);

    logic [IXW-1:0] ahead;

    // --------------------
    // Count columns that rank ahead of this one
    // --------------------
    // Smaller word wins, equal words fall back to the lower column
    always_comb begin
        ahead = '0;
        for (int c = 0; c < COL; c++) begin
            if (c != INDEX) begin
                if ((i_frame[c] < i_frame[INDEX]) ||
                    ((i_frame[c] == i_frame[INDEX]) && (c < INDEX))) begin
                    ahead = ahead + 1'b1;
                end
            end
        end
    end

    // Rank held until the next frame is ranked
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_rank <= '0;
        end else if (i_rank) begin
            o_rank <= ahead;
        end
    end

    // A freshly registered rank must name a real slot of the buffer
    a_rank_in_range: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_rank |=> (o_rank < COL)
    );

endmodule

/* design/beam_buffer.sv */
module beam_buffer
    import sort_cfg_pkg::*;
#(
    parameter int IW   = DEF_IW,
    parameter int COL  = DEF_COL,
    localparam int IXW = (COL > 1) ? $clog2(COL) : 1
) (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_load,
    input  logic [COL-1:0][IW-1:0]  i_data,
    input  logic                    i_scatter,
    input  logic [COL-1:0][IXW-1:0] i_ranks,
    input  logic [IXW-1:0]          i_beat,
    output logic [COL-1:0][IW-1:0]  o_frame,
    output logic [IW-1:0]           o_data,
    output logic [IXW-1:0]          o_index
);

    logic [COL-1:0][IW-1:0]  frame_q;
    logic [COL-1:0][IW-1:0]  slot_data;
    logic [COL-1:0][IXW-1:0] slot_index;
    logic [COL-1:0]          rank_hit;

    // --------------------
    // Frame capture
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_load) begin
            frame_q <= i_data;
        end
    end

    assign o_frame = frame_q;

    // --------------------
    // Scatter into sorted slots
    // --------------------
    // Slot n ends up holding the word of rank n and where it came from
    always_ff @(posedge i_clk) begin
        if (i_scatter) begin
            for (int c = 0; c < COL; c++) begin
                slot_data[i_ranks[c]]  <= frame_q[c];
                slot_index[i_ranks[c]] <= IXW'(c);
            end
        end
    end

    // Beat number picks the slot
    assign o_data  = slot_data[i_beat];
    assign o_index = slot_index[i_beat];

    // Which slots the current rank set would fill
    always_comb begin
        rank_hit = '0;
        for (int c = 0; c < COL; c++) begin
            rank_hit[i_ranks[c]] = 1'b1;
        end
    end

    // Comparators must hand out a permutation, otherwise slots get lost
    a_ranks_unique: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_scatter |-> (&rank_hit)
    );

endmodule

/* design/beam_counter.sv */
module beam_counter
    import sort_cfg_pkg::*;
#(
    parameter int BEAM = DEF_BEAM,
    parameter int COL  = DEF_COL,
    localparam int IXW = (COL > 1) ? $clog2(COL) : 1
) (
    input  logic           i_clk,
    input  logic           i_reset,
    input  logic           i_clear,
    input  logic           i_step,
    output logic [IXW-1:0] o_beat,
    output logic           o_last_beat
);

    localparam logic [IXW-1:0] LAST_BEAT = IXW'(BEAM - 1);

    // --------------------
    // Beat counter
    // --------------------
    // Clear wins, a new frame always starts at beat 0
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_beat <= '0;
        end else if (i_clear) begin
            o_beat <= '0;
        end else if (i_step) begin
            o_beat <= o_beat + 1'b1;
        end
    end

    assign o_last_beat = (o_beat == LAST_BEAT);

    // Sequencer must leave emit once the final beat has gone out
    a_no_overstep: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_step |-> (o_beat <= LAST_BEAT)
    );

    // Stepping off the final beat means the stream is over
    a_stop_after_last: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (i_step && o_last_beat) |=> !i_step
    );

endmodule

/* design/sort_fsm.sv */
module sort_fsm
    import sort_ctrl_pkg::*;
(
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_start,
    input  logic i_last_beat,
    output logic o_load,
    output logic o_rank,
    output logic o_scatter,
    output logic o_emit,
    output logic o_busy,
    output logic o_valid,
    output logic o_last
);

    sort_state_t state_q;
    sort_state_t state_d;

    // --------------------
    // State register
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (i_start) begin
                    state_d = ST_RANK;
                end
            end
            ST_RANK: begin
                state_d = ST_SCATTER;
            end
            ST_SCATTER: begin
                state_d = ST_EMIT;
            end
            ST_EMIT: begin
                // One beat per cycle until the counter flags the last one
                if (i_last_beat) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // --------------------
    // Strobes
    // --------------------
    // Start only counts when idle
    assign o_load    = (state_q == ST_IDLE) && i_start;
    assign o_rank    = (state_q == ST_RANK);
    assign o_scatter = (state_q == ST_SCATTER);
    assign o_emit    = (state_q == ST_EMIT);
    assign o_busy    = (state_q != ST_IDLE);
    assign o_valid   = o_emit;
    assign o_last    = o_emit && i_last_beat;

    a_valid_busy: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_valid |-> o_busy
    );

endmodule

/* design/beam_sort_top.sv */
module beam_sort_top
    import sort_cfg_pkg::*;
#(
    parameter int IW   = DEF_IW,
    parameter int COL  = DEF_COL,
    parameter int BEAM = DEF_BEAM,
    localparam int IXW = (COL > 1) ? $clog2(COL) : 1
) (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_start,
    input  logic [COL-1:0][IW-1:0] i_data,
    output logic                   o_busy,
    output logic                   o_valid,
    output logic                   o_last,
    output logic [IW-1:0]          o_data,
    output logic [IXW-1:0]         o_index
);

    logic                    load;
    logic                    rank;
    logic                    scatter;
    logic                    emit;
    logic                    last_beat;
    logic [IXW-1:0]          beat;
    logic [COL-1:0][IW-1:0]  frame;
    logic [COL-1:0][IXW-1:0] ranks;

    // --------------------
    // Sequencer
    // --------------------
    sort_fsm u_sort_fsm (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_start     (i_start),
        .i_last_beat (last_beat),
        .o_load      (load),
        .o_rank      (rank),
        .o_scatter   (scatter),
        .o_emit      (emit),
        .o_busy      (o_busy),
        .o_valid     (o_valid),
        .o_last      (o_last)
    );

    // Beat count restarts with every accepted frame
    beam_counter #(
        .BEAM (BEAM),
        .COL  (COL)
    ) u_beam_counter (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_clear     (load),
        .i_step      (emit),
        .o_beat      (beat),
        .o_last_beat (last_beat)
    );

    // --------------------
    // Frame and sorted slots
    // --------------------
    beam_buffer #(
        .IW  (IW),
        .COL (COL)
    ) u_beam_buffer (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_load    (load),
        .i_data    (i_data),
        .i_scatter (scatter),
        .i_ranks   (ranks),
        .i_beat    (beat),
        .o_frame   (frame),
        .o_data    (o_data),
        .o_index   (o_index)
    );

    // --------------------
    // One comparator per column
    // --------------------
    for (genvar g = 0; g < COL; g++) begin : g_rank
        rank_compare #(
            .IW    (IW),
            .COL   (COL),
            .INDEX (g)
        ) u_rank_compare (
            .i_clk   (i_clk),
            .i_reset (i_reset),
            .i_rank  (rank),
            .i_frame (frame),
            .o_rank  (ranks[g])
        );
    end

endmodule

/* verification/beam_sort_tb.sv */
module beam_sort_tb
    import sort_cfg_pkg::*;
;

    localparam int IW           = DEF_IW;
    localparam int COL          = DEF_COL;
    localparam int BEAM         = DEF_BEAM;
    localparam int IXW          = (COL > 1) ? $clog2(COL) : 1;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int RANDOM_RUNS  = 20;
    // Frame runs plus the idle windows between directed tests
    localparam int NUM_TESTS    = RANDOM_RUNS + 8;

    logic                   clk;
    logic                   reset;
    logic                   start;
    logic [COL-1:0][IW-1:0] data;
    logic                   busy;
    logic                   valid;
    logic                   last;
    logic [IW-1:0]          out_data;
    logic [IXW-1:0]         out_index;

    logic [IW-1:0]          exp_data [COL];
    logic [IXW-1:0]         exp_index [COL];
    logic [31:0]            lfsr_state;
    logic [COL-1:0][IW-1:0] frame;

    beam_sort_top i_beam_sort_top (
        .i_clk   (clk),
        .i_reset (reset),
        .i_start (start),
        .i_data  (data),
        .o_busy  (busy),
        .o_valid (valid),
        .o_last  (last),
        .o_data  (out_data),
        .o_index (out_index)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------
    // Failure handling and compares
    // --------------------
    task automatic stop_with_failure(input string reason);
        $display("Some tests failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_data(input string name, input logic [IW-1:0] exp,
                              input logic [IW-1:0] act);
        if (act !== exp) begin
            $display("error %s: expected %0h, actual %0h", name, exp, act);
            stop_with_failure("data mismatch");
        end
    endtask

    task automatic check_index(input string name, input logic [IXW-1:0] exp,
                               input logic [IXW-1:0] act);
        if (act !== exp) begin
            $display("error %s: expected %0d, actual %0d", name, exp, act);
            stop_with_failure("index mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error %s: expected %b, actual %b", name, exp, act);
            stop_with_failure("strobe mismatch");
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("error %s: expected %0d, actual %0d", name, exp, act);
            stop_with_failure("latency mismatch");
        end
    endtask

    // --------------------
    // Stimulus helpers
    // --------------------
    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    function automatic logic [IW-1:0] random_word(input int nbits);
        logic [IW-1:0] word;
        word = '0;
        for (int b = 0; b < nbits; b++) begin
            word = {word[IW-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return word;
    endfunction

    // Back to the drive point of the next cycle
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // Stable insertion sort keeps equal words in column order
    task automatic reference_sort(input logic [COL-1:0][IW-1:0] frm);
        int pos;
        for (int i = 0; i < COL; i++) begin
            pos = i;
            while (pos > 0 && exp_data[pos-1] > frm[i]) begin
                exp_data[pos]  = exp_data[pos-1];
                exp_index[pos] = exp_index[pos-1];
                pos--;
            end
            exp_data[pos]  = frm[i];
            exp_index[pos] = IXW'(i);
        end
    endtask

    task automatic quiet_cycles(input string name, input int count);
        for (int n = 0; n < count; n++) begin
            @(negedge clk);
            check_bit({name, " busy"}, 1'b0, busy);
            check_bit({name, " valid"}, 1'b0, valid);
            check_bit({name, " last"}, 1'b0, last);
            next_cycle();
        end
    endtask

    // Starts one frame and optionally pokes a second start while busy
    task automatic run_frame(input string name, input logic [COL-1:0][IW-1:0] frm,
                             input bit poke);
        int cycles;
        reference_sort(frm);
        start = 1'b1;
        data  = frm;
        @(negedge clk);
        check_bit({name, " idle at start"}, 1'b0, busy);
        next_cycle();
        start  = poke;
        data   = ~frm;
        cycles = 1;
        forever begin
            @(negedge clk);
            if (valid) begin
                break;
            end
            check_bit({name, " busy before beats"}, 1'b1, busy);
            if (cycles > BEAM + 10) begin
                stop_with_failure("o_valid never rose after the start strobe");
            end
            next_cycle();
            start = 1'b0;
            cycles++;
        end
        check_count({name, " latency"}, 3, cycles);
        for (int b = 0; b < BEAM; b++) begin
            if (b > 0) begin
                next_cycle();
                @(negedge clk);
            end
            check_bit({name, " valid"}, 1'b1, valid);
            check_bit({name, " busy"}, 1'b1, busy);
            check_bit({name, " last"}, (b == BEAM - 1), last);
            check_data({name, " data"}, exp_data[b], out_data);
            check_index({name, " index"}, exp_index[b], out_index);
        end
        next_cycle();
    endtask

    // --------------------
    // Watchdog
    // --------------------
    initial begin
        #((NUM_TESTS * (BEAM + 10) + RESET_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired before the tests completed");
        stop_with_failure("timeout");
    end

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        start      = 1'b0;
        data       = '0;
        lfsr_state = 32'he460dce8;

        // Outputs stay low through reset
        repeat (RESET_CYCLES - 1) begin
            next_cycle();
            @(negedge clk);
            check_bit("reset busy", 1'b0, busy);
            check_bit("reset valid", 1'b0, valid);
            check_bit("reset last", 1'b0, last);
        end
        next_cycle();
        reset = 1'b0;
        quiet_cycles("idle_after_reset", 4);

        // Distinct words, scrambled
        for (int c = 0; c < COL; c++) begin
            frame[c] = IW'(((c * 5 + 3) % COL) * 100 + 7);
        end
        run_frame("distinct", frame, 1'b0);
        quiet_cycles("distinct_tail", 3);

        // Ties resolved by column
        for (int c = 0; c < COL; c++) begin
            frame[c] = IW'(((COL - c) % 3) * 10);
        end
        run_frame("duplicates", frame, 1'b0);
        for (int c = 0; c < COL; c++) begin
            frame[c] = IW'(16'h0055);
        end
        run_frame("all_equal", frame, 1'b0);
        quiet_cycles("equal_tail", 3);

        // Second start during busy
        for (int c = 0; c < COL; c++) begin
            frame[c] = IW'((COL - c) * 3);
        end
        run_frame("start_while_busy", frame, 1'b1);
        quiet_cycles("busy_start_tail", 4);

        // Back to back random frames
        // Odd runs use 3-bit words to force ties
        for (int t = 0; t < RANDOM_RUNS; t++) begin
            for (int c = 0; c < COL; c++) begin
                frame[c] = (t % 2 == 1) ? random_word(3) : random_word(IW);
            end
            run_frame($sformatf("random_%0d", t), frame, 1'b0);
        end
        quiet_cycles("random_tail", 2);

        $display("All tests passed");
        $finish;
    end

endmodule

/* verilog.f */
design/sort_cfg_pkg.sv
design/sort_ctrl_pkg.sv
design/rank_compare.sv
design/beam_buffer.sv
design/beam_counter.sv
design/sort_fsm.sv
design/beam_sort_top.sv
verification/beam_sort_tb.sv
